//--- verilog/bmd_pkg.sv
//--------------------------------------------------------------------------
// Bus-master DMA endpoint shared definitions
// Widths, register map, transmit beat and status word layout
//--------------------------------------------------------------------------
package bmd_pkg;

    //----------------------------------------------------------------------
    // Widths
    //----------------------------------------------------------------------
    localparam int DATA_W     = 32;     // Transmit word and register width
    localparam int SAMPLE_W   = 12;     // One ADC sample
    localparam int LEN_W      = 8;      // Words per buffer
    localparam int REG_ADDR_W = 3;
    localparam int TAG_W      = 8;

    typedef logic [31:0] addr_t;        // Buffer address
    typedef logic [31:0] word_t;        // Packed sample pair

    //----------------------------------------------------------------------
    // Register map
    //----------------------------------------------------------------------
    localparam logic [REG_ADDR_W-1:0] REG_CTRL      = 3'd0;
    localparam logic [REG_ADDR_W-1:0] REG_MWR_LEN   = 3'd1;
    localparam logic [REG_ADDR_W-1:0] REG_BUF_PUSH  = 3'd2;  // Write only
    localparam logic [REG_ADDR_W-1:0] REG_DONE_POP  = 3'd3;  // Read pops
    localparam logic [REG_ADDR_W-1:0] REG_STATUS    = 3'd4;
    localparam logic [REG_ADDR_W-1:0] REG_TLP_COUNT = 3'd5;

    localparam int CTRL_RUN_BIT      = 0;  // Level
    localparam int CTRL_INIT_RST_BIT = 1;  // Self-clearing pulse

    // One beat on the transmit side, header or data
    typedef struct packed {
        logic              sof;
        logic              eof;
        logic [TAG_W-1:0]  tag;
        logic [LEN_W-1:0]  len;
        logic [DATA_W-1:0] data;    // Address on header, sample word otherwise
    } mwr_beat_t;

    // Status register with busy in the top bit
    typedef struct packed {
        logic       busy;
        logic [6:0] rsvd;
        logic [7:0] drop_cnt;       // Saturates at 255
        logic [7:0] done_cnt;
        logic [7:0] free_cnt;
    } status_t;

endpackage

//--- verilog/bmd_fifo.sv
`timescale 1ns/1ps
//--------------------------------------------------------------------------
// Synchronous FIFO with a type-parameter payload
// Head visible without latency, occupancy count for status
//--------------------------------------------------------------------------
module bmd_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 16
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       clear_i,
    input  logic       push_i,
    input  payload_t   din_i,
    input  logic       pop_i,
    output payload_t   dout_o,
    output logic       empty_o,
    output logic       full_o,
    output logic [7:0] count_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [7:0]       count_q;
    logic             do_push;
    logic             do_pop;

    // Wrap explicitly so non power-of-two depths work
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign do_push = push_i && !full_o;     // Push into full queue ignored
    assign do_pop  = pop_i && !empty_o;
    assign full_o  = (count_q == 8'(DEPTH));
    assign empty_o = (count_q == 8'd0);
    assign dout_o  = mem[rd_ptr];
    assign count_o = count_q;

    always_ff @(posedge clk) begin
        if (!rst_n || clear_i) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count_q <= '0;
        end else begin
            if (do_push) wr_ptr <= ptr_inc(wr_ptr);
            if (do_pop)  rd_ptr <= ptr_inc(rd_ptr);
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 8'd1;
                2'b01:   count_q <= count_q - 8'd1;
                default: count_q <= count_q;     // Both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr] <= din_i;
    end

endmodule

//--- verilog/bmd_regs.sv
`timescale 1ns/1ps
//--------------------------------------------------------------------------
// Host register block
// Run and length registers, initiator reset pulse, buffer queue access
//--------------------------------------------------------------------------
module bmd_regs (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           reg_wr_i,
    input  logic                           reg_rd_i,
    input  logic [bmd_pkg::REG_ADDR_W-1:0] reg_addr_i,
    input  logic [bmd_pkg::DATA_W-1:0]     reg_wdata_i,
    output logic                           rd_valid_o,
    output logic [bmd_pkg::DATA_W-1:0]     rd_data_o,
    output logic                           run_o,
    output logic                           init_rst_o,
    output logic [bmd_pkg::LEN_W-1:0]      mwr_len_o,
    output logic                           buf_push_o,
    output bmd_pkg::addr_t                 buf_addr_o,
    output logic                           done_pop_o,
    input  bmd_pkg::addr_t                 done_head_i,
    input  logic                           done_empty_i,
    input  bmd_pkg::status_t               status_i,
    input  logic [bmd_pkg::DATA_W-1:0]     tlp_count_i
);

    import bmd_pkg::*;

    logic              run_q;
    logic              init_rst_q;
    logic [LEN_W-1:0]  len_q;
    logic              rd_valid_q;
    logic [DATA_W-1:0] rd_data_q;
    logic [DATA_W-1:0] rd_mux;
    logic              wr_ctrl;
    logic              wr_len;

    assign wr_ctrl = reg_wr_i && (reg_addr_i == REG_CTRL);
    assign wr_len  = reg_wr_i && (reg_addr_i == REG_MWR_LEN);

    // Queue strobes go straight to the FIFOs, which update on the next edge
    assign buf_push_o = reg_wr_i && (reg_addr_i == REG_BUF_PUSH);
    assign buf_addr_o = reg_wdata_i;
    assign done_pop_o = reg_rd_i && (reg_addr_i == REG_DONE_POP) && !done_empty_i;

    //----------------------------------------------------------------------
    // Read mux
    //----------------------------------------------------------------------
    always_comb begin
        case (reg_addr_i)
            REG_CTRL:      rd_mux = {{(DATA_W-1){1'b0}}, run_q};
            REG_MWR_LEN:   rd_mux = {{(DATA_W-LEN_W){1'b0}}, len_q};
            REG_DONE_POP:  rd_mux = done_empty_i ? '0 : done_head_i;
            REG_STATUS:    rd_mux = status_i;
            REG_TLP_COUNT: rd_mux = tlp_count_i;
            default:       rd_mux = '0;     // Unmapped and write-only
        endcase
    end

    //----------------------------------------------------------------------
    // Control registers
    //----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            run_q      <= 1'b0;
            len_q      <= '0;
            init_rst_q <= 1'b0;
            rd_valid_q <= 1'b0;
        end else begin
            init_rst_q <= wr_ctrl && reg_wdata_i[CTRL_INIT_RST_BIT];  // One cycle
            rd_valid_q <= reg_rd_i;
            if (wr_ctrl) begin
                run_q <= reg_wdata_i[CTRL_RUN_BIT];
            end
            if (wr_len) begin
                len_q <= reg_wdata_i[LEN_W-1:0];
            end
        end
    end

    // Head is captured in the same cycle the pop is issued
    always_ff @(posedge clk) begin
        if (reg_rd_i) begin
            rd_data_q <= rd_mux;
        end
    end

    assign rd_valid_o = rd_valid_q;
    assign rd_data_o  = rd_data_q;
    assign run_o      = run_q;
    assign init_rst_o = init_rst_q;
    assign mwr_len_o  = len_q;

endmodule

//--- verilog/bmd_sample_pack.sv
`timescale 1ns/1ps
//--------------------------------------------------------------------------
// ADC sample packer
// Two 12-bit samples per word, counts words lost to a full queue
//--------------------------------------------------------------------------
module bmd_sample_pack (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         init_rst_i,
    input  logic                         adc_valid_i,
    input  logic [bmd_pkg::SAMPLE_W-1:0] adc1_i,
    input  logic [bmd_pkg::SAMPLE_W-1:0] adc2_i,
    input  logic                         sample_full_i,
    output logic                         push_o,
    output bmd_pkg::word_t               word_o,
    output logic [7:0]                   drop_count_o
);

    import bmd_pkg::*;

    localparam int HI_LSB = 16;     // adc2 lane

    logic       pend_q;
    word_t      word_q;
    logic [7:0] drop_q;

    // Fullness is judged when the word reaches the queue
    assign push_o       = pend_q && !sample_full_i;
    assign word_o       = word_q;
    assign drop_count_o = drop_q;

    always_ff @(posedge clk) begin
        if (!rst_n || init_rst_i) begin
            pend_q <= 1'b0;
            drop_q <= '0;
        end else begin
            pend_q <= adc_valid_i;
            if (pend_q && sample_full_i && drop_q != 8'hff) begin
                drop_q <= drop_q + 8'd1;    // Saturating
            end
        end
    end

    always_ff @(posedge clk) begin
        if (adc_valid_i) begin
            word_q <= {{(DATA_W-HI_LSB-SAMPLE_W){1'b0}}, adc2_i,
                       {(HI_LSB-SAMPLE_W){1'b0}}, adc1_i};
        end
    end

endmodule

//--- verilog/bmd_mwr_engine.sv
`timescale 1ns/1ps
//--------------------------------------------------------------------------
// Memory-write engine
// One header beat then a programmed number of data beats per free buffer
//--------------------------------------------------------------------------
module bmd_mwr_engine (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      init_rst_i,
    input  logic                      run_i,
    input  logic [bmd_pkg::LEN_W-1:0] mwr_len_i,
    input  logic                      free_empty_i,
    input  bmd_pkg::addr_t            free_head_i,
    output logic                      free_pop_o,
    input  logic [7:0]                sample_count_i,
    input  bmd_pkg::word_t            sample_head_i,
    output logic                      sample_pop_o,
    input  logic                      done_full_i,
    output logic                      done_push_o,
    output bmd_pkg::addr_t            done_addr_o,
    output logic                      tx_valid_o,
    output bmd_pkg::mwr_beat_t        tx_beat_o,
    input  logic                      tx_ready_i,
    output logic                      busy_o,
    output logic [31:0]               tlp_count_o
);

    import bmd_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_HDR,
        ST_DATA
    } state_t;

    state_t           state_q;
    logic [TAG_W-1:0] tag_q;
    logic [31:0]      tlp_count_q;
    logic [LEN_W-1:0] remain_q;     // Data beats still to send
    logic [LEN_W-1:0] len_q;
    addr_t            addr_q;
    logic             start;
    logic             hdr_xfer;
    logic             data_xfer;
    logic             last_beat;

    // A whole buffer's worth of samples must be queued before starting
    assign start = (state_q == ST_IDLE) && run_i && !free_empty_i && !done_full_i
                 && (mwr_len_i != '0) && (sample_count_i >= mwr_len_i);

    assign hdr_xfer  = (state_q == ST_HDR) && tx_ready_i;
    assign data_xfer = (state_q == ST_DATA) && tx_ready_i;
    assign last_beat = (remain_q == LEN_W'(1));

    assign free_pop_o   = hdr_xfer;
    assign sample_pop_o = data_xfer;
    assign done_push_o  = data_xfer && last_beat;
    assign done_addr_o  = addr_q;
    assign tx_valid_o   = (state_q != ST_IDLE);
    assign busy_o       = (state_q != ST_IDLE);
    assign tlp_count_o  = tlp_count_q;

    //----------------------------------------------------------------------
    // Beat formation held stable while stalled
    //----------------------------------------------------------------------
    always_comb begin
        tx_beat_o     = '0;
        tx_beat_o.tag = tag_q;
        tx_beat_o.len = len_q;
        case (state_q)
            ST_HDR: begin
                tx_beat_o.sof  = 1'b1;
                tx_beat_o.data = addr_q;
            end
            ST_DATA: begin
                tx_beat_o.eof  = last_beat;
                tx_beat_o.data = sample_head_i;     // Head only moves on transfer
            end
            default: tx_beat_o.data = '0;
        endcase
    end

    //----------------------------------------------------------------------
    // FSM and counters
    //----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n || init_rst_i) begin
            state_q     <= ST_IDLE;     // Abandons a transaction in flight
            tag_q       <= '0;
            tlp_count_q <= '0;
            remain_q    <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (start) begin
                        state_q  <= ST_HDR;
                        remain_q <= mwr_len_i;
                    end
                end
                ST_HDR: begin
                    if (hdr_xfer) state_q <= ST_DATA;
                end
                ST_DATA: begin
                    if (data_xfer) begin
                        remain_q <= remain_q - 1'b1;
                        if (last_beat) begin
                            state_q     <= ST_IDLE;
                            tag_q       <= tag_q + 1'b1;    // Wraps at 256
                            tlp_count_q <= tlp_count_q + 32'd1;
                        end
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // Buffer address and length latched for the whole transaction
    always_ff @(posedge clk) begin
        if (start) begin
            addr_q <= free_head_i;
            len_q  <= mwr_len_i;
        end
    end

endmodule

//--- verilog/bmd_ep.sv
`timescale 1ns/1ps
//--------------------------------------------------------------------------
// Bus-master DMA endpoint, memory-write side
// Free and done address queues, sample queue, registers and write engine
//--------------------------------------------------------------------------
module bmd_ep #(
    parameter int ADDR_DEPTH   = 16,
    parameter int SAMPLE_DEPTH = 64
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           reg_wr_i,
    input  logic                           reg_rd_i,
    input  logic [bmd_pkg::REG_ADDR_W-1:0] reg_addr_i,
    input  logic [bmd_pkg::DATA_W-1:0]     reg_wdata_i,
    output logic                           rd_valid_o,
    output logic [bmd_pkg::DATA_W-1:0]     rd_data_o,
    input  logic                           adc_valid_i,
    input  logic [bmd_pkg::SAMPLE_W-1:0]   adc1_i,
    input  logic [bmd_pkg::SAMPLE_W-1:0]   adc2_i,
    output logic                           tx_valid_o,
    output bmd_pkg::mwr_beat_t             tx_beat_o,
    input  logic                           tx_ready_i
);

    import bmd_pkg::*;

    logic             run;
    logic             init_rst;
    logic [LEN_W-1:0] mwr_len;
    logic             busy;
    logic [31:0]      tlp_count;
    status_t          status;

    logic             buf_push;
    addr_t            buf_addr;
    logic             free_pop;
    addr_t            free_head;
    logic             free_empty;
    logic [7:0]       free_count;

    logic             done_push;
    addr_t            done_addr;
    logic             done_pop;
    addr_t            done_head;
    logic             done_empty;
    logic             done_full;
    logic [7:0]       done_count;

    logic             sample_push;
    word_t            sample_word;
    logic             sample_pop;
    word_t            sample_head;
    logic             sample_full;
    logic [7:0]       sample_count;
    logic [7:0]       drop_count;

    assign status = '{busy: busy, rsvd: '0, drop_cnt: drop_count,
                      done_cnt: done_count, free_cnt: free_count};

    bmd_regs u_regs (
        .clk, .rst_n, .reg_wr_i, .reg_rd_i, .reg_addr_i, .reg_wdata_i,
        .rd_valid_o, .rd_data_o,
        .run_o(run), .init_rst_o(init_rst), .mwr_len_o(mwr_len),
        .buf_push_o(buf_push), .buf_addr_o(buf_addr),
        .done_pop_o(done_pop), .done_head_i(done_head), .done_empty_i(done_empty),
        .status_i(status), .tlp_count_i(tlp_count)
    );

    //----------------------------------------------------------------------
    // Queues cleared by the initiator reset
    //----------------------------------------------------------------------
    bmd_fifo #(.payload_t(addr_t), .DEPTH(ADDR_DEPTH)) u_free_q (
        .clk, .rst_n, .clear_i(init_rst),
        .push_i(buf_push), .din_i(buf_addr), .pop_i(free_pop), .dout_o(free_head),
        .empty_o(free_empty), .full_o(), .count_o(free_count)   // Host push when full drops
    );

    bmd_fifo #(.payload_t(addr_t), .DEPTH(ADDR_DEPTH)) u_done_q (
        .clk, .rst_n, .clear_i(init_rst),
        .push_i(done_push), .din_i(done_addr), .pop_i(done_pop), .dout_o(done_head),
        .empty_o(done_empty), .full_o(done_full), .count_o(done_count)
    );

    bmd_fifo #(.payload_t(word_t), .DEPTH(SAMPLE_DEPTH)) u_sample_q (
        .clk, .rst_n, .clear_i(init_rst),
        .push_i(sample_push), .din_i(sample_word), .pop_i(sample_pop),
        .dout_o(sample_head), .empty_o(), .full_o(sample_full), .count_o(sample_count)
    );

    bmd_sample_pack u_pack (
        .clk, .rst_n, .init_rst_i(init_rst),
        .adc_valid_i, .adc1_i, .adc2_i,
        .sample_full_i(sample_full), .push_o(sample_push), .word_o(sample_word),
        .drop_count_o(drop_count)
    );

    bmd_mwr_engine u_engine (
        .clk, .rst_n, .init_rst_i(init_rst), .run_i(run), .mwr_len_i(mwr_len),
        .free_empty_i(free_empty), .free_head_i(free_head), .free_pop_o(free_pop),
        .sample_count_i(sample_count), .sample_head_i(sample_head),
        .sample_pop_o(sample_pop),
        .done_full_i(done_full), .done_push_o(done_push), .done_addr_o(done_addr),
        .tx_valid_o, .tx_beat_o, .tx_ready_i,
        .busy_o(busy), .tlp_count_o(tlp_count)
    );

endmodule

//--- tb/bmd_ep_sva.sv
`timescale 1ns/1ps
//--------------------------------------------------------------------------
// Endpoint assertions on the transmit handshake, beat framing and pushes
//--------------------------------------------------------------------------
module bmd_ep_sva (
    input logic                clk,
    input logic                rst_n,
    input logic                init_rst_i,
    input logic                tx_valid_i,
    input logic                tx_ready_i,
    input bmd_pkg::mwr_beat_t  tx_beat_i,
    input logic                done_push_i,
    input logic                done_full_i
);

    import bmd_pkg::*;

    int unsigned      fail_cnt = 0;
    logic [LEN_W-1:0] remain_q;     // Data beats owed since the last header
    logic             xfer;

    assign xfer = tx_valid_i && tx_ready_i;

    always_ff @(posedge clk) begin
        if (!rst_n || init_rst_i) begin
            remain_q <= '0;
        end else if (xfer) begin
            remain_q <= tx_beat_i.sof ? tx_beat_i.len : remain_q - 1'b1;
        end
    end

    a_stall_stable: assert property (@(posedge clk) disable iff (!rst_n)
        tx_valid_i && !tx_ready_i && !init_rst_i |=> tx_valid_i && $stable(tx_beat_i))
        else begin $error("Stalled beat changed"); fail_cnt++; end

    a_sof_framing: assert property (@(posedge clk) disable iff (!rst_n)
        xfer && tx_beat_i.sof |-> remain_q == '0 && tx_beat_i.len != '0)
        else begin $error("Header inside a transaction"); fail_cnt++; end

    a_data_count: assert property (@(posedge clk) disable iff (!rst_n)
        xfer && !tx_beat_i.sof |-> remain_q != '0 && (tx_beat_i.eof == (remain_q == LEN_W'(1))))
        else begin $error("Data beat count does not match len"); fail_cnt++; end

    a_done_push: assert property (@(posedge clk) disable iff (!rst_n)
        done_push_i |-> !done_full_i)
        else begin $error("Done queue pushed when full"); fail_cnt++; end

endmodule

bind bmd_ep bmd_ep_sva i_sva (
    .clk, .rst_n, .init_rst_i(init_rst), .tx_valid_i(tx_valid_o), .tx_ready_i,
    .tx_beat_i(tx_beat_o), .done_push_i(done_push), .done_full_i(done_full)
);

//--- tb/bmd_ep_tb.sv
`timescale 1ns/1ps
//--------------------------------------------------------------------------
// Testbench for the bus-master DMA endpoint, memory-write side
// Register access, ADC stimulus, beat reference model and monitor
//--------------------------------------------------------------------------
module bmd_ep_tb;

    import bmd_pkg::*;

    localparam int          TIMEOUT = 2000;            // Cycles per wait loop
    localparam logic [31:0] SEED    = 32'h79b16625;

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  reg_wr_i;
    logic                  reg_rd_i;
    logic [REG_ADDR_W-1:0] reg_addr_i;
    logic [DATA_W-1:0]     reg_wdata_i;
    logic                  rd_valid_o;
    logic [DATA_W-1:0]     rd_data_o;
    logic                  adc_valid_i;
    logic [SAMPLE_W-1:0]   adc1_i;
    logic [SAMPLE_W-1:0]   adc2_i;
    logic                  tx_valid_o;
    mwr_beat_t             tx_beat_o;
    logic                  tx_ready_i;

    logic [31:0]         smp_seed = SEED;
    logic [31:0]         rdy_seed = SEED;
    logic                rand_ready;
    logic [SAMPLE_W-1:0] a1_mem [70];
    logic [SAMPLE_W-1:0] a2_mem [70];
    addr_t               bufs [3] = '{32'h1000_0000, 32'h1000_4000, 32'h2000_8000};
    mwr_beat_t           exp_q [$];                     // Predicted beats in order
    int                  errors;
    int                  test_err;
    int                  tests_ok;
    int                  tests_bad;

    bmd_ep #(.ADDR_DEPTH(16), .SAMPLE_DEPTH(64)) i_bmd_ep (.*);

    always #50 clk = ~clk;

    //----------------------------------------------------------------------
    // Reference model
    //----------------------------------------------------------------------
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // adc2 in bits 27:16, adc1 in bits 11:0
    function automatic word_t pack_ref(input logic [11:0] a1, input logic [11:0] a2);
        word_t w;
        w        = '0;
        w[27:16] = a2;
        w[11:0]  = a1;
        return w;
    endfunction

    function automatic logic [31:0] status_ref(input int free_c, input int done_c,
                                               input int drop_c, input bit busy);
        return {busy, 7'd0, 8'(drop_c), 8'(done_c), 8'(free_c)};
    endfunction

    task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic expect_buffers(input int nbuf, input int len);
        mwr_beat_t b;
        for (int k = 0; k < nbuf; k++) begin
            b      = '0;
            b.sof  = 1'b1;                              // Header
            b.tag  = 8'(k);
            b.len  = 8'(len);
            b.data = bufs[k];
            exp_q.push_back(b);
            for (int j = 0; j < len; j++) begin
                b      = '0;
                b.eof  = (j == len - 1);
                b.tag  = 8'(k);
                b.len  = 8'(len);
                b.data = pack_ref(a1_mem[k*len+j], a2_mem[k*len+j]);
                exp_q.push_back(b);
            end
        end
    endtask

    //----------------------------------------------------------------------
    // Bus and ADC drivers on the falling edge
    //----------------------------------------------------------------------
    task automatic reg_write(input logic [2:0] addr, input logic [31:0] data);
        @(negedge clk);
        reg_wr_i    = 1'b1;
        reg_addr_i  = addr;
        reg_wdata_i = data;
        @(negedge clk);
        reg_wr_i    = 1'b0;
    endtask

    task automatic read_expect(input string name, input logic [2:0] addr, input logic [31:0] exp);
        int n;
        n = 0;
        @(negedge clk);
        reg_rd_i   = 1'b1;
        reg_addr_i = addr;
        @(negedge clk);
        reg_rd_i   = 1'b0;
        while (!rd_valid_o && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!rd_valid_o) begin
            $display("Timeout: no read response for %s", name);
            $display("Verification failed");
            $finish;
        end
        check({name, " latency"}, 0, n);               // One cycle after the strobe
        check(name, exp, rd_data_o);
    endtask

    task automatic push_buffers(input int nbuf);
        for (int k = 0; k < nbuf; k++) reg_write(REG_BUF_PUSH, bufs[k]);
    endtask

    task automatic gen_samples(input int n);
        for (int i = 0; i < n; i++) begin
            smp_seed  = lcg_next(smp_seed);
            a1_mem[i] = smp_seed[31:20];                // Upper LCG bits
            a2_mem[i] = smp_seed[19:8];
        end
    endtask

    task automatic drive_samples(input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            adc_valid_i = 1'b1;
            adc1_i      = a1_mem[i];
            adc2_i      = a2_mem[i];
        end
        @(negedge clk);
        adc_valid_i = 1'b0;
        repeat (2) @(negedge clk);                      // Let the last word settle
    endtask

    task automatic wait_beats;
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("Timeout: %0d predicted beats never transferred", exp_q.size());
            $display("Verification failed");
            $finish;
        end
    endtask

    task automatic end_test(input string name);
        if (errors == test_err) begin
            tests_ok++;
            $display("Test %s: ok", name);
        end else begin
            tests_bad++;
            $display("Test %s: FAILED", name);
        end
        test_err = errors;
    endtask

    always @(negedge clk) begin
        rdy_seed   = lcg_next(rdy_seed);
        tx_ready_i = rand_ready ? rdy_seed[31] : 1'b1;
    end

    // Monitor compares every transferred beat with the prediction
    always @(posedge clk) begin
        if (rst_n && tx_valid_o && tx_ready_i) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("Unexpected transmit beat with data %h", tx_beat_o.data);
            end else begin
                check("tx_beat", exp_q.pop_front(), tx_beat_o);
            end
        end
    end

    //----------------------------------------------------------------------
    // Test sequence
    //----------------------------------------------------------------------
    initial begin
        rst_n       = 1'b0;
        reg_wr_i    = 1'b0;
        reg_rd_i    = 1'b0;
        reg_addr_i  = '0;
        reg_wdata_i = '0;
        adc_valid_i = 1'b0;
        adc1_i      = '0;
        adc2_i      = '0;
        tx_ready_i  = 1'b1;
        rand_ready  = 1'b0;
        errors      = 0;
        test_err    = 0;
        tests_ok    = 0;
        tests_bad   = 0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;

        check("tx_valid after reset", 0, tx_valid_o);
        check("rd_valid after reset", 0, rd_valid_o);
        read_expect("status after reset", REG_STATUS, 0);
        read_expect("tlp count after reset", REG_TLP_COUNT, 0);
        end_test("reset");

        reg_write(REG_MWR_LEN, 32'h0000_00a5);
        read_expect("mwr_len readback", REG_MWR_LEN, 32'h0000_00a5);
        read_expect("unmapped 6", 3'd6, 0);
        read_expect("unmapped 7", 3'd7, 0);
        end_test("registers");

        push_buffers(3);
        reg_write(REG_MWR_LEN, 32'd4);
        reg_write(REG_CTRL, 32'h1);                     // Run
        gen_samples(12);
        expect_buffers(3, 4);
        drive_samples(12);
        wait_beats();
        end_test("three transactions");

        reg_write(REG_CTRL, 32'h3);                     // Initiator reset, run kept
        rand_ready = 1'b1;
        push_buffers(3);
        expect_buffers(3, 4);                           // Same stream replayed
        drive_samples(12);
        wait_beats();
        rand_ready = 1'b0;
        read_expect("tlp count after back-pressure", REG_TLP_COUNT, 3);
        end_test("back-pressure");

        for (int k = 0; k < 3; k++) read_expect("done pop", REG_DONE_POP, bufs[k]);
        read_expect("done pop when empty", REG_DONE_POP, 0);
        read_expect("status after drain", REG_STATUS, status_ref(0, 0, 0, 1'b0));
        end_test("done drain");

        gen_samples(70);
        drive_samples(70);                              // Queue holds 64
        read_expect("status with drops", REG_STATUS, status_ref(0, 0, 6, 1'b0));
        reg_write(REG_CTRL, 32'h3);
        read_expect("status after init reset", REG_STATUS, 0);
        read_expect("tlp count after init reset", REG_TLP_COUNT, 0);
        push_buffers(1);
        gen_samples(4);
        expect_buffers(1, 4);                           // Tag back at 0
        drive_samples(4);
        wait_beats();
        end_test("drops and init reset");

        check("assertion failures", 0, i_bmd_ep.i_sva.fail_cnt);
        $display("Tests: %0d ok, %0d failed, %0d check errors", tests_ok, tests_bad, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- src.f
verilog/bmd_pkg.sv
verilog/bmd_fifo.sv
verilog/bmd_regs.sv
verilog/bmd_sample_pack.sv
verilog/bmd_mwr_engine.sv
verilog/bmd_ep.sv
tb/bmd_ep_sva.sv
tb/bmd_ep_tb.sv

//--- Bender.yml
package:
  name: bmd_ep

sources:
  # RTL
  - verilog/bmd_pkg.sv
  - verilog/bmd_fifo.sv
  - verilog/bmd_regs.sv
  - verilog/bmd_sample_pack.sv
  - verilog/bmd_mwr_engine.sv
  - verilog/bmd_ep.sv
  # Testbench
  - target: test
    files:
      - tb/bmd_ep_sva.sv
      - tb/bmd_ep_tb.sv
